/* riscv_core.f */
+incdir+testbench
hdl/riscv_pkg.sv
hdl/bypass_if.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/operand_bypass.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/riscv_core.sv
testbench/tb_riscv_core.sv

/* testbench/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// ======================================================================
// Program and expected stores
// ======================================================================
localparam int prog_len    = 30;
localparam int store_count = 10;

// Load at 0x5c, use at 0x60, so the PC sits on 0x64 for the stall cycle
localparam word_t load_use_hold_addr = 32'h0000_0064;

// Expected store, data is either value or a preloaded word plus value
typedef struct packed {
    word_t      addr;
    logic       from_mem;
    logic [5:0] mem_idx;
    word_t      value;
} store_exp_t;

word_t      prog [prog_len];
store_exp_t exp_stores [store_count];

function automatic store_exp_t literal_store(input word_t addr, input word_t value);
    store_exp_t e;
    e.addr     = addr;
    e.from_mem = 1'b0;
    e.mem_idx  = '0;
    e.value    = value;
    return e;
endfunction

function automatic store_exp_t preload_store(input word_t addr, input logic [5:0] idx,
                                             input word_t addend);
    store_exp_t e;
    e.addr     = addr;
    e.from_mem = 1'b1;
    e.mem_idx  = idx;
    e.value    = addend;
    return e;
endfunction

task automatic build_program();
    // Forwarding distances 1 to 3 and signed results
    prog[0]  = i_type(3'b000, 1, 0, 12'd100);          // x1 = 100
    prog[1]  = i_type(3'b000, 2, 0, 12'hff9);          // x2 = -7
    prog[2]  = i_type(3'b000, 6, 0, 12'd2);            // x6 = 2
    prog[3]  = r_type(7'h20, 3'b000, 4, 2, 1);         // x4 = x2 - x1
    prog[4]  = r_type(7'h20, 3'b101, 5, 4, 6);         // x5 = x4 >>> x6
    prog[5]  = r_type(7'h00, 3'b010, 7, 5, 1);         // x7 = x5 < x1
    prog[6]  = store_word(7, 0, 12'd128);
    prog[7]  = store_word(5, 0, 12'd132);
    prog[8]  = store_word(4, 0, 12'd136);
    prog[9]  = r_type(7'h00, 3'b011, 8, 1, 2);         // sltu
    prog[10] = r_type(7'h00, 3'b100, 9, 8, 1);         // xor
    prog[11] = store_word(9, 0, 12'd140);
    // Immediates and shifts
    prog[12] = upper_imm(11, 20'h12345);
    prog[13] = i_type(3'b110, 11, 11, 12'h678);        // ori
    prog[14] = i_type(3'b101, 12, 11, 12'h004);        // srli
    prog[15] = i_type(3'b001, 13, 11, 12'h008);        // slli
    prog[16] = r_type(7'h00, 3'b110, 14, 12, 13);      // or
    prog[17] = store_word(14, 0, 12'd144);
    prog[18] = i_type(3'b101, 15, 2, 12'h401);         // srai
    prog[19] = i_type(3'b111, 16, 15, 12'h0f0);        // andi
    prog[20] = store_word(16, 0, 12'd148);
    // x0 stays zero
    prog[21] = i_type(3'b000, 0, 1, 12'd55);
    prog[22] = store_word(0, 0, 12'd152);
    // Load-use pair, then a load consumed at distance 2
    prog[23] = load_word(18, 0, 12'd8);
    prog[24] = i_type(3'b000, 19, 18, 12'd5);
    prog[25] = store_word(19, 0, 12'd156);
    prog[26] = load_word(20, 0, 12'd12);
    prog[27] = r_type(7'h00, 3'b000, 21, 1, 0);
    prog[28] = store_word(20, 0, 12'd160);
    prog[29] = store_word(21, 0, 12'd164);
endtask

task automatic build_expected_stores();
    exp_stores[0] = literal_store(32'h80, 32'h0000_0001);
    exp_stores[1] = literal_store(32'h84, 32'hffff_ffe5);
    exp_stores[2] = literal_store(32'h88, 32'hffff_ff95);
    exp_stores[3] = literal_store(32'h8c, 32'h0000_0065);
    exp_stores[4] = literal_store(32'h90, 32'h3577_7d67);
    exp_stores[5] = literal_store(32'h94, 32'h0000_00f0);
    exp_stores[6] = literal_store(32'h98, 32'h0000_0000);
    exp_stores[7] = preload_store(32'h9c, 6'd2, 32'd5);
    exp_stores[8] = preload_store(32'ha0, 6'd3, 32'd0);
    exp_stores[9] = literal_store(32'ha4, 32'h0000_0064);
endtask

`endif

/* testbench/tb_riscv_core.sv */
`timescale 1ns/10ps

module tb_riscv_core;
    import riscv_pkg::*;

    localparam int store_timeout = 50;
    localparam int dmem_words    = 64;

    logic   clk;
    logic   rst;
    word_t  imem_addr;
    word_t  imem_data;
    logic   dmem_read;
    logic   dmem_write;
    word_t  dmem_addr;
    word_t  dmem_wdata;
    word_t  dmem_rdata;

    int     errors;
    int     checks;
    integer seed;
    word_t  dmem [dmem_words];
    word_t  dmem_init [dmem_words];

    // PC tracking state
    word_t  prev_addr;
    word_t  hold_addr;
    int     hold_count;
    int     post_cycles;

    // ======================================================================
    // Instruction encoders
    // ======================================================================
    function automatic word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                     input reg_idx_t rd, input reg_idx_t rs1,
                                     input reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t i_type(input logic [2:0] f3, input reg_idx_t rd,
                                     input reg_idx_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, op_imm};
    endfunction

    function automatic word_t load_word(input reg_idx_t rd, input reg_idx_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, op_load};
    endfunction

    function automatic word_t store_word(input reg_idx_t rs2, input reg_idx_t rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t upper_imm(input reg_idx_t rd, input logic [19:0] imm);
        return {imm, rd, op_lui};
    endfunction

    `include "tb_program.svh"

    riscv_core i_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_read  (dmem_read),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    // Step at least one falling edge and poll for the next store
    task automatic wait_for_store(output bit timed_out);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while ((dmem_write !== 1'b1) && (cycles < store_timeout));
        timed_out = (dmem_write !== 1'b1);
    endtask

    // ======================================================================
    // Memory models updated on the falling edge
    // ======================================================================
    always @(negedge clk) begin
        // Past the table the core sees an all-zero word that decodes as a bubble
        if (imem_addr[31:2] < prog_len) begin
            imem_data <= prog[imem_addr[31:2]];
        end else begin
            imem_data <= '0;
        end
        // Read data only while the core qualifies the access
        if (dmem_read === 1'b1) begin
            dmem_rdata <= dmem[dmem_addr[7:2]];
        end else begin
            dmem_rdata <= '0;
        end
        if (dmem_write === 1'b1) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // PC and memory qualifiers around reset and the stall count
    always @(negedge clk) begin
        if (rst) begin
            check_value("imem_addr", imem_addr, pc_reset);
            check_value("dmem_read", word_t'(dmem_read), '0);
            check_value("dmem_write", word_t'(dmem_write), '0);
            prev_addr   = imem_addr;
            post_cycles = 0;
        end else begin
            post_cycles++;
            // Nothing reaches EX/MEM before the third edge
            if (post_cycles <= 2) begin
                check_value("dmem_read", word_t'(dmem_read), '0);
                check_value("dmem_write", word_t'(dmem_write), '0);
            end
            if (imem_addr == prev_addr) begin
                hold_count++;
                hold_addr = imem_addr;
            end else begin
                check_value("imem_addr", imem_addr, prev_addr + 32'd4);
            end
            prev_addr = imem_addr;
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        int    s;
        bit    timed_out;
        word_t exp_data;

        errors     = 0;
        checks     = 0;
        hold_count = 0;
        hold_addr  = '0;
        seed       = 32'h98693e07;
        clk        = 1'b0;
        rst        = 1'b1;
        imem_data  = '0;
        dmem_rdata = '0;
        build_program();
        build_expected_stores();
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i]      = $random(seed);
            dmem_init[i] = dmem[i];
        end

        repeat (8) @(negedge clk);
        rst <= 1'b0;

        // One pass over the store table
        timed_out = 1'b0;
        for (s = 0; (s < store_count) && !timed_out; s++) begin
            wait_for_store(timed_out);
            if (timed_out) begin
                errors++;
                $display("Timed out waiting for store %0d of %0d", s, store_count);
            end else begin
                exp_data = exp_stores[s].value;
                if (exp_stores[s].from_mem) begin
                    exp_data = dmem_init[exp_stores[s].mem_idx] + exp_stores[s].value;
                end
                check_value("dmem_addr", dmem_addr, exp_stores[s].addr);
                check_value("dmem_wdata", dmem_wdata, exp_data);
            end
        end

        // Exactly one stall cycle on the instruction after the load-use pair
        @(posedge clk);
        check_value("imem_addr hold count", hold_count, 1);
        check_value("imem_addr hold address", hold_addr, load_use_hold_addr);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* hdl/riscv_core.sv */
`timescale 1ns/10ps

module riscv_core (
    input  logic              clk,
    input  logic              rst,
    output riscv_pkg::word_t  imem_addr,
    input  riscv_pkg::word_t  imem_data,
    output logic              dmem_read,
    output logic              dmem_write,
    output riscv_pkg::word_t  dmem_addr,
    output riscv_pkg::word_t  dmem_wdata,
    input  riscv_pkg::word_t  dmem_rdata
);
    import riscv_pkg::*;

    logic                 stall;
    word_t                if_id_instr;
    id_ex_t               id_ex;
    word_t [num_src-1:0]  operand;
    logic                 ex_mem_write;
    reg_idx_t             ex_mem_rd;
    word_t                ex_mem_value;
    word_t                ex_mem_store_data;
    logic                 ex_mem_read;
    logic                 ex_mem_store;
    logic                 ex_mem_to_reg;

    bypass_if byp ();

    // ======================================================================
    // Pipeline stages
    // ======================================================================
    fetch_stage i_fetch (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .if_id_instr (if_id_instr)
    );

    decode_stage i_decode (
        .clk         (clk),
        .rst         (rst),
        .if_id_instr (if_id_instr),
        .stall       (stall),
        .id_ex       (id_ex),
        .byp         (byp)
    );

    // One forwarding mux per source operand
    for (genvar i = 0; i < num_src; i++) begin : g_src
        operand_bypass i_bypass (
            .src_idx   (id_ex.rs[i]),
            .reg_value (id_ex.rs_data[i]),
            .byp       (byp),
            .operand   (operand[i])
        );
    end

    execute_stage i_execute (
        .clk               (clk),
        .rst               (rst),
        .id_ex             (id_ex),
        .operand           (operand),
        .ex_mem_write      (ex_mem_write),
        .ex_mem_rd         (ex_mem_rd),
        .ex_mem_value      (ex_mem_value),
        .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_read       (ex_mem_read),
        .ex_mem_store      (ex_mem_store),
        .ex_mem_to_reg     (ex_mem_to_reg)
    );

    mem_wb_stage i_mem_wb (
        .clk               (clk),
        .rst               (rst),
        .ex_mem_write      (ex_mem_write),
        .ex_mem_rd         (ex_mem_rd),
        .ex_mem_value      (ex_mem_value),
        .ex_mem_store_data (ex_mem_store_data),
        .ex_mem_read       (ex_mem_read),
        .ex_mem_store      (ex_mem_store),
        .ex_mem_to_reg     (ex_mem_to_reg),
        .dmem_read         (dmem_read),
        .dmem_write        (dmem_write),
        .dmem_addr         (dmem_addr),
        .dmem_wdata        (dmem_wdata),
        .dmem_rdata        (dmem_rdata),
        .byp               (byp)
    );

endmodule

/* hdl/mem_wb_stage.sv */
`timescale 1ns/10ps

module mem_wb_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 ex_mem_write,
    input  riscv_pkg::reg_idx_t  ex_mem_rd,
    input  riscv_pkg::word_t     ex_mem_value,
    input  riscv_pkg::word_t     ex_mem_store_data,
    input  logic                 ex_mem_read,
    input  logic                 ex_mem_store,
    input  logic                 ex_mem_to_reg,
    output logic                 dmem_read,
    output logic                 dmem_write,
    output riscv_pkg::word_t     dmem_addr,
    output riscv_pkg::word_t     dmem_wdata,
    input  riscv_pkg::word_t     dmem_rdata,
    bypass_if.source             byp
);
    import riscv_pkg::*;

    logic      mem_wb_write;
    logic      mem_wb_to_reg;
    reg_idx_t  mem_wb_rd;
    word_t     mem_wb_alu;
    word_t     mem_wb_load;

    // Data memory port, straight from EX/MEM
    assign dmem_read  = ex_mem_read;
    assign dmem_write = ex_mem_store;
    assign dmem_addr  = ex_mem_value;
    assign dmem_wdata = ex_mem_store_data;

    // MEM/WB flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wb_write  <= 1'b0;
            mem_wb_to_reg <= 1'b0;
        end else begin
            mem_wb_write  <= ex_mem_write;
            mem_wb_to_reg <= ex_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        mem_wb_rd   <= ex_mem_rd;
        mem_wb_alu  <= ex_mem_value;
        mem_wb_load <= dmem_rdata;
    end

    // A load in EX/MEM only holds its address, so it is not offered for forwarding
    assign byp.ex_mem_write = ex_mem_write && !ex_mem_to_reg;
    assign byp.ex_mem_rd    = ex_mem_rd;
    assign byp.ex_mem_value = ex_mem_value;

    // Writeback select
    assign byp.wb_write = mem_wb_write;
    assign byp.wb_rd    = mem_wb_rd;
    assign byp.wb_value = mem_wb_to_reg ? mem_wb_load : mem_wb_alu;

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(dmem_read && dmem_write));

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic                                        clk,
    input  logic                                        rst,
    input  riscv_pkg::id_ex_t                           id_ex,
    input  riscv_pkg::word_t [riscv_pkg::num_src-1:0]   operand,
    output logic                                        ex_mem_write,
    output riscv_pkg::reg_idx_t                         ex_mem_rd,
    output riscv_pkg::word_t                            ex_mem_value,
    output riscv_pkg::word_t                            ex_mem_store_data,
    output logic                                        ex_mem_read,
    output logic                                        ex_mem_store,
    output logic                                        ex_mem_to_reg
);
    import riscv_pkg::*;

    word_t       op_a;
    word_t       op_b;
    word_t       alu_result;
    logic [4:0]  shamt;

    // Operand selection, forwarded rs1 always feeds port A
    assign op_a  = operand[0];
    assign op_b  = id_ex.alu_src_imm ? id_ex.imm : operand[1];
    assign shamt = op_b[4:0];

    // ======================================================================
    // ALU
    // ======================================================================
    always_comb begin
        case (id_ex.alu_op)
            alu_add:    alu_result = op_a + op_b;
            alu_sub:    alu_result = op_a - op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_or:     alu_result = op_a | op_b;
            alu_xor:    alu_result = op_a ^ op_b;
            alu_sll:    alu_result = op_a << shamt;
            alu_srl:    alu_result = op_a >> shamt;
            alu_sra:    alu_result = word_t'($signed(op_a) >>> shamt);
            alu_slt:    alu_result = word_t'($signed(op_a) < $signed(op_b));
            alu_sltu:   alu_result = word_t'(op_a < op_b);
            alu_pass_b: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    // EX/MEM control flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_mem_write  <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_store  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
        end else begin
            ex_mem_write  <= id_ex.reg_write;
            ex_mem_read   <= id_ex.mem_read;
            ex_mem_store  <= id_ex.mem_write;
            ex_mem_to_reg <= id_ex.mem_to_reg;
        end
    end

    // EX/MEM payload, store data is the forwarded rs2
    always_ff @(posedge clk) begin
        ex_mem_rd         <= id_ex.rd;
        ex_mem_value      <= alu_result;
        ex_mem_store_data <= operand[1];
    end

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  riscv_pkg::word_t   if_id_instr,
    output logic               stall,
    output riscv_pkg::id_ex_t  id_ex,
    bypass_if.sink             byp
);
    import riscv_pkg::*;

    logic [6:0]             opcode;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    word_t                  imm_i;
    word_t                  imm_s;
    word_t                  imm_u;
    id_ex_t                 dec;
    word_t [num_src-1:0]    src_data;

    // Map funct3 plus the funct7 alternate bit onto an ALU function
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    assign opcode = if_id_instr[6:0];
    assign funct3 = if_id_instr[14:12];
    assign funct7 = if_id_instr[31:25];

    // ======================================================================
    // Immediate generation
    // ======================================================================
    assign imm_i = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
    assign imm_s = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
    assign imm_u = {if_id_instr[31:12], 12'b0};

    // ======================================================================
    // Control decode
    // ======================================================================
    // Unused source fields are forced to x0 so that immediate bits
    // never trigger a false stall or a forward
    always_comb begin
        dec    = '0;
        dec.rd = if_id_instr[11:7];
        case (opcode)
            op_reg: begin
                dec.rs[0]     = if_id_instr[19:15];
                dec.rs[1]     = if_id_instr[24:20];
                dec.reg_write = 1'b1;
                dec.alu_op    = alu_decode(funct3, funct7[5]);
            end
            op_imm: begin
                dec.rs[0]       = if_id_instr[19:15];
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                // Only SRAI uses the alternate bit, ADDI has no subtract form
                dec.alu_op      = alu_decode(funct3, (funct3 == 3'b101) && funct7[5]);
            end
            op_load: begin
                dec.rs[0]       = if_id_instr[19:15];
                dec.imm         = imm_i;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                dec.mem_read    = 1'b1;
                dec.mem_to_reg  = 1'b1;
            end
            op_store: begin
                dec.rs[0]       = if_id_instr[19:15];
                dec.rs[1]       = if_id_instr[24:20];
                dec.imm         = imm_s;
                dec.alu_src_imm = 1'b1;
                dec.mem_write   = 1'b1;
            end
            op_lui: begin
                dec.imm         = imm_u;
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                dec.alu_op      = alu_pass_b;
            end
            // Anything else travels down as a bubble
            default: dec.rd = '0;
        endcase
    end

    // Register file with write-through from writeback
    reg_file i_reg_file (
        .clk   (clk),
        .rst   (rst),
        .raddr (dec.rs),
        .rdata (src_data),
        .byp   (byp)
    );

    // Load-use hazard
    // Load data only exists after MEM, one cycle too late for the next EX
    assign stall = id_ex.mem_read && (id_ex.rd != '0) &&
                   ((id_ex.rd == dec.rs[0]) || (id_ex.rd == dec.rs[1]));

    // ID/EX register, a stall drops a bubble in behind the load
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            id_ex <= '0;
        end else if (stall) begin
            id_ex <= '0;
        end else begin
            id_ex         <= dec;
            id_ex.rs_data <= src_data;
        end
    end

    // The bubble clears mem_read, so the hazard can never persist
    a_single_stall: assert property (@(posedge clk) disable iff (rst) stall |=> !stall);

endmodule

/* hdl/operand_bypass.sv */
`timescale 1ns/10ps

module operand_bypass (
    input  riscv_pkg::reg_idx_t  src_idx,
    input  riscv_pkg::word_t     reg_value,
    bypass_if.sink               byp,
    output riscv_pkg::word_t     operand
);

    logic hit_ex_mem;
    logic hit_wb;

    // x0 is hardwired, so it never matches a producer
    assign hit_ex_mem = byp.ex_mem_write && (src_idx != '0) && (byp.ex_mem_rd == src_idx);
    assign hit_wb     = byp.wb_write && (src_idx != '0) && (byp.wb_rd == src_idx);

    // Youngest producer wins
    // EX/MEM first, then writeback, then the value captured in decode
    always_comb begin
        if (hit_ex_mem) begin
            operand = byp.ex_mem_value;
        end else if (hit_wb) begin
            operand = byp.wb_value;
        end else begin
            operand = reg_value;
        end
    end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/10ps

module reg_file (
    input  logic                                           clk,
    input  logic                                           rst,
    input  riscv_pkg::reg_idx_t [riscv_pkg::num_src-1:0]   raddr,
    output riscv_pkg::word_t    [riscv_pkg::num_src-1:0]   rdata,
    bypass_if.sink                                         byp
);
    import riscv_pkg::*;

    word_t regs [num_regs];

    // Single write port driven from writeback, x0 is never written
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int r = 0; r < num_regs; r++) begin
                regs[r] <= '0;
            end
        end else if (byp.wb_write && (byp.wb_rd != '0)) begin
            regs[byp.wb_rd] <= byp.wb_value;
        end
    end

    // Read ports
    // A same-cycle write shows through, so ID/EX captures the new value
    always_comb begin
        for (int p = 0; p < num_src; p++) begin
            if (byp.wb_write && (byp.wb_rd != '0) && (byp.wb_rd == raddr[p])) begin
                rdata[p] = byp.wb_value;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

    for (genvar i = 0; i < num_src; i++) begin : g_x0_chk
        a_x0_zero: assert property (@(posedge clk) disable iff (rst)
            (raddr[i] == '0) |-> (rdata[i] == '0));
    end

endmodule

/* hdl/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    output riscv_pkg::word_t  imem_addr,
    input  riscv_pkg::word_t  imem_data,
    output riscv_pkg::word_t  if_id_instr
);
    import riscv_pkg::*;

    word_t pc;

    // Instruction memory is combinational, the word at pc arrives this cycle
    assign imem_addr = pc;

    // Program counter
    // Sequential only, frozen while decode holds a load-use pair
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= pc_reset;
        end else if (!stall) begin
            pc <= pc + word_t'(4);
        end
    end

    // IF/ID register
    // All-zero word has no valid opcode, so decode sees a bubble after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            if_id_instr <= '0;
        end else if (!stall) begin
            if_id_instr <= imem_data;
        end
    end

endmodule

/* hdl/bypass_if.sv */
`timescale 1ns/10ps

// Results still in flight, fed back to decode and to the EX bypass muxes
interface bypass_if;
    import riscv_pkg::*;

    // Result sitting in the EX/MEM register
    logic     ex_mem_write;
    reg_idx_t ex_mem_rd;
    word_t    ex_mem_value;

    // Result being written back this cycle
    logic     wb_write;
    reg_idx_t wb_rd;
    word_t    wb_value;

    modport source (
        output ex_mem_write, ex_mem_rd, ex_mem_value,
        output wb_write, wb_rd, wb_value
    );

    modport sink (
        input ex_mem_write, ex_mem_rd, ex_mem_value,
        input wb_write, wb_rd, wb_value
    );

endinterface

/* hdl/riscv_pkg.sv */
package riscv_pkg;

    // ======================================================================
    // Widths and sizes
    // ======================================================================
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int num_regs   = 32;
    // Source operands per instruction, rs1 and rs2
    localparam int num_src    = 2;

    localparam logic [xlen-1:0] pc_reset = '0;

    // ======================================================================
    // RV32I major opcodes in the supported subset
    // ======================================================================
    localparam logic [6:0] op_reg   = 7'b0110011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_lui   = 7'b0110111;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;

    // ALU functions, pass B carries the LUI immediate straight through
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_sll    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_slt    = 4'd8,
        alu_sltu   = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    // ID/EX payload
    // Index 0 is rs1 and index 1 is rs2 in both arrays
    typedef struct packed {
        reg_idx_t [num_src-1:0] rs;
        word_t    [num_src-1:0] rs_data;
        word_t                  imm;
        reg_idx_t               rd;
        alu_op_e                alu_op;
        logic                   alu_src_imm;
        logic                   reg_write;
        logic                   mem_read;
        logic                   mem_write;
        logic                   mem_to_reg;
    } id_ex_t;

endpackage
